// File: include/cmd_in_settings.svh
`ifndef CMD_IN_SETTINGS_SVH
`define CMD_IN_SETTINGS_SVH

// Accelerators and queue geometry
`define CMD_MAX_ACCS        4
`define CMD_ACC_BITS        2
`define CMD_SUBQUEUE_BITS   6   // 64 words per subqueue
`define CMD_QUEUE_ADDR_BITS (`CMD_ACC_BITS + `CMD_SUBQUEUE_BITS)
`define CMD_WORD_BITS       64

// Host bus
`define APB_ADDR_BITS       12
`define APB_DATA_BITS       32

// Header fields, listed from bit 63 down
`define CMD_RSVD_BITS       7
`define CMD_TYPE_BITS       4
`define CMD_NARGS_BITS      4
`define CMD_PAYLOAD_BITS    48

// Command type codes
`define CMD_CODE_EXEC       4'h1
`define CMD_CODE_SETUP      4'h2
`define CMD_CODE_PERIODIC   4'h3

`endif

// File: logic/cmd_in_pkg.sv
`include "cmd_in_settings.svh"

package cmd_in_pkg;

    typedef enum logic [`CMD_TYPE_BITS-1:0] {
        CMD_EXEC     = `CMD_CODE_EXEC,
        CMD_SETUP    = `CMD_CODE_SETUP,
        CMD_PERIODIC = `CMD_CODE_PERIODIC
    } cmd_type_e;

    // Header word found at the front of a subqueue
    typedef struct packed {
        logic                           valid;      // Bit 63, set by the host
        logic [`CMD_RSVD_BITS-1:0]      rsvd;
        cmd_type_e                      cmd_type;
        logic [`CMD_NARGS_BITS-1:0]     num_args;
        logic [`CMD_PAYLOAD_BITS-1:0]   payload;
    } cmd_header_s;

    typedef union packed {
        cmd_header_s                hdr;
        logic [`CMD_WORD_BITS-1:0]  raw;
    } cmd_word_u;

    typedef logic [`CMD_ACC_BITS-1:0]        acc_id_t;
    typedef logic [`CMD_SUBQUEUE_BITS-1:0]   sub_idx_t;
    // Accelerator number in the upper bits, subqueue index below
    typedef logic [`CMD_QUEUE_ADDR_BITS-1:0] queue_addr_t;

endpackage

// File: logic/cmd_in_ifs.sv
`timescale 1ns/1ps

// Dispatcher port of the queue memory
interface cmd_ram_if import cmd_in_pkg::*; ();
    queue_addr_t addr;
    logic        en;
    logic        we;
    cmd_word_u   din;
    cmd_word_u   dout;     // Valid one cycle after a read

    modport ram (input addr, input en, input we, input din, output dout);
    modport user (output addr, output en, output we, output din, input dout);
endinterface

// Grant and report between scheduler and dispatcher
interface sched_if import cmd_in_pkg::*; ();
    logic     grant;       // Held until done
    acc_id_t  acc_id;
    sub_idx_t front_idx;
    logic     done;
    logic     advance;
    sub_idx_t next_idx;
    logic     mark_busy;

    modport sched (output grant, output acc_id, output front_idx,
                   input done, input advance, input next_idx, input mark_busy);
    modport disp (input grant, input acc_id, input front_idx,
                  output done, output advance, output next_idx, output mark_busy);
endinterface

// File: logic/apb_queue_port.sv
`timescale 1ns/1ps
`include "cmd_in_settings.svh"

module apb_queue_port import cmd_in_pkg::*; (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic [`APB_ADDR_BITS-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`APB_DATA_BITS-1:0] pwdata,
    output logic [`APB_DATA_BITS-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    output queue_addr_t               ram_addr,
    output logic                      ram_we,
    output cmd_word_u                 ram_din,
    input  cmd_word_u                 ram_dout
);

    logic [`APB_DATA_BITS-1:0] low_half;
    logic                      rd_wait;
    logic                      access;
    logic                      hi_sel;

    assign access = psel & penable;
    assign hi_sel = paddr[2];

    // Byte address to word address
    assign ram_addr = paddr[3 +: `CMD_QUEUE_ADDR_BITS];

    // High half commits the whole word
    assign ram_we  = access & pwrite & hi_sel;
    assign ram_din = cmd_word_u'({pwdata, low_half});

    assign prdata  = hi_sel ? ram_dout.raw[2*`APB_DATA_BITS-1:`APB_DATA_BITS]
                            : ram_dout.raw[`APB_DATA_BITS-1:0];
    assign pready  = pwrite | rd_wait;
    assign pslverr = 1'b0;

    always_ff @(posedge clk) begin
        if (access && pwrite && !hi_sel) begin
            low_half <= pwdata;
        end
    end

    // One wait state while the memory read settles
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rd_wait <= 1'b0;
        end else begin
            rd_wait <= access & !pwrite & !rd_wait;
        end
    end

endmodule

// File: logic/cmd_queue_ram.sv
`timescale 1ns/1ps
`include "cmd_in_settings.svh"

module cmd_queue_ram import cmd_in_pkg::*; (
    input  logic        clk,
    input  queue_addr_t host_addr,
    input  logic        host_we,
    input  cmd_word_u   host_din,
    output cmd_word_u   host_dout,
    cmd_ram_if.ram      ram
);

    localparam int DEPTH = `CMD_MAX_ACCS << `CMD_SUBQUEUE_BITS;

    // One circular subqueue per accelerator
    cmd_word_u mem [DEPTH];

    // Host port, read every cycle
    always @(posedge clk) begin
        if (host_we) begin
            mem[host_addr] <= host_din;
        end
        host_dout <= mem[host_addr];
    end

    // Dispatcher port
    always @(posedge clk) begin
        if (ram.en) begin
            if (ram.we) begin
                mem[ram.addr] <= ram.din;
            end else begin
                ram.dout <= mem[ram.addr];
            end
        end
    end

endmodule

// File: logic/acc_scheduler.sv
`timescale 1ns/1ps
`include "cmd_in_settings.svh"

module acc_scheduler import cmd_in_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  logic    acc_done,
    input  acc_id_t acc_done_id,
    sched_if.sched  sched
);

    acc_id_t                  ptr;
    logic [`CMD_MAX_ACCS-1:0] avail;
    sub_idx_t                 front [`CMD_MAX_ACCS];
    acc_id_t                  cand;
    logic                     found;

    // First available accelerator at or after the pointer
    always_comb begin : scan
        acc_id_t probe;
        found = 1'b0;
        cand  = ptr;
        for (int i = `CMD_MAX_ACCS - 1; i >= 0; i--) begin
            probe = ptr + acc_id_t'(i);
            if (avail[probe]) begin
                found = 1'b1;
                cand  = probe;
            end
        end
    end

    assign sched.front_idx = front[sched.acc_id];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ptr          <= '0;
            avail        <= '1;
            sched.grant  <= 1'b0;
            sched.acc_id <= '0;
            for (int i = 0; i < `CMD_MAX_ACCS; i++) begin
                front[i] <= '0;
            end
        end else begin
            if (!sched.grant) begin
                if (found) begin
                    sched.grant  <= 1'b1;
                    sched.acc_id <= cand;
                    ptr          <= cand + 1'b1;
                end
            end else if (sched.done) begin
                if (sched.advance) front[sched.acc_id] <= sched.next_idx;
                if (sched.mark_busy) avail[sched.acc_id] <= 1'b0;
                sched.grant <= 1'b0;
            end
            if (acc_done) avail[acc_done_id] <= 1'b1;   // Completion wins over a new busy mark
        end
    end

endmodule

// File: logic/cmd_dispatcher.sv
`timescale 1ns/1ps
`include "cmd_in_settings.svh"

module cmd_dispatcher import cmd_in_pkg::*; (
    input  logic                      clk,
    input  logic                      rstn,
    cmd_ram_if.user                   ram,
    sched_if.disp                     sched,
    output logic [`CMD_WORD_BITS-1:0] stream_data,
    output logic                      stream_valid,
    input  logic                      stream_ready,
    output acc_id_t                   stream_dest,
    output logic                      stream_last
);

    typedef enum logic [2:0] {
        IDLE,
        ISSUE,
        CHECK,
        SEND,
        CLEAR
    } state_e;

    state_e     state;
    sub_idx_t   idx;        // Next word to read
    logic [5:0] cnt;        // Words left after the current one
    logic [5:0] cmd_len;    // Up to 4 + 2*15
    logic       is_setup;
    logic       hdr_valid;

    assign hdr_valid = ram.dout.hdr.valid;

    always_comb begin
        case (ram.dout.hdr.cmd_type)
            CMD_SETUP: cmd_len = 6'd2;
            CMD_EXEC:  cmd_len = 6'd3 + {1'b0, ram.dout.hdr.num_args, 1'b0};
            default:   cmd_len = 6'd4 + {1'b0, ram.dout.hdr.num_args, 1'b0};
        endcase
    end

    // Memory requests
    always_comb begin
        ram.en   = 1'b0;
        ram.we   = 1'b0;
        ram.addr = {sched.acc_id, sched.front_idx};
        ram.din  = '0;      // Cleared header, valid bit low
        case (state)
            ISSUE: ram.en = 1'b1;
            SEND: begin
                if (stream_ready && cnt != '0) begin
                    ram.en   = 1'b1;
                    ram.addr = {sched.acc_id, idx};
                end
            end
            CLEAR: begin
                ram.en = 1'b1;
                ram.we = 1'b1;
            end
            default: ;
        endcase
    end

    // Memory output holds while no read is issued
    assign stream_data  = ram.dout.raw;
    assign stream_valid = state == SEND;
    assign stream_dest  = sched.acc_id;
    assign stream_last  = cnt == '0;

    assign sched.done      = (state == CLEAR) || (state == CHECK && !hdr_valid);
    assign sched.advance   = state == CLEAR;
    assign sched.mark_busy = (state == CLEAR) && !is_setup;
    assign sched.next_idx  = idx;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (sched.grant) state <= ISSUE;
                ISSUE:   state <= CHECK;
                CHECK:   state <= hdr_valid ? SEND : IDLE;   // Empty slot means no work
                SEND:    if (stream_ready && stream_last) state <= CLEAR;
                CLEAR:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            ISSUE: idx <= sched.front_idx + 1'b1;
            CHECK: begin
                cnt      <= cmd_len - 1'b1;
                is_setup <= ram.dout.hdr.cmd_type == CMD_SETUP;
            end
            SEND: begin
                if (stream_ready && !stream_last) begin
                    idx <= idx + 1'b1;      // Wraps inside the subqueue
                    cnt <= cnt - 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: logic/cmd_in_top.sv
`timescale 1ns/1ps
`include "cmd_in_settings.svh"

module cmd_in_top import cmd_in_pkg::*; (
    input  logic                      clk,
    input  logic                      rstn,
    // APB host port
    input  logic [`APB_ADDR_BITS-1:0] paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [`APB_DATA_BITS-1:0] pwdata,
    output logic [`APB_DATA_BITS-1:0] prdata,
    output logic                      pready,
    output logic                      pslverr,
    // Command stream to the accelerators
    output logic [`CMD_WORD_BITS-1:0] stream_data,
    output logic                      stream_valid,
    input  logic                      stream_ready,
    output logic [`CMD_ACC_BITS-1:0]  stream_dest,
    output logic                      stream_last,
    // Completion reports
    input  logic                      acc_done,
    input  logic [`CMD_ACC_BITS-1:0]  acc_done_id
);

    queue_addr_t host_addr;
    logic        host_we;
    cmd_word_u   host_din;
    cmd_word_u   host_dout;

    cmd_ram_if ram_bus ();
    sched_if   sched_bus ();

    apb_queue_port i_apb (
        .clk      (clk),
        .rstn     (rstn),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .ram_addr (host_addr),
        .ram_we   (host_we),
        .ram_din  (host_din),
        .ram_dout (host_dout)
    );

    cmd_queue_ram i_ram (
        .clk       (clk),
        .host_addr (host_addr),
        .host_we   (host_we),
        .host_din  (host_din),
        .host_dout (host_dout),
        .ram       (ram_bus.ram)
    );

    acc_scheduler i_sched (
        .clk         (clk),
        .rstn        (rstn),
        .acc_done    (acc_done),
        .acc_done_id (acc_done_id),
        .sched       (sched_bus.sched)
    );

    cmd_dispatcher i_disp (
        .clk          (clk),
        .rstn         (rstn),
        .ram          (ram_bus.user),
        .sched        (sched_bus.disp),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .stream_ready (stream_ready),
        .stream_dest  (stream_dest),
        .stream_last  (stream_last)
    );

endmodule

// File: verif/tb_cmd_in.sv
`timescale 1ns/1ps
`include "cmd_in_settings.svh"

module tb_cmd_in import cmd_in_pkg::*; ();

    localparam int          CLK_PERIOD = 100;
    localparam int          NUM_CMDS   = 6 + 2 + 2 + 8 + 8 + 16;
    localparam int          SUB_DEPTH  = 1 << `CMD_SUBQUEUE_BITS;
    localparam logic [31:0] SEED       = 32'h5f38;

    typedef struct packed {
        cmd_word_u word;
        logic      last;
        logic      blocks;     // Accelerator goes busy after this word
    } exp_s;

    logic                      clk;
    logic                      rstn;
    logic [`APB_ADDR_BITS-1:0] paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`APB_DATA_BITS-1:0] pwdata;
    logic [`APB_DATA_BITS-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
    logic [`CMD_WORD_BITS-1:0] stream_data;
    logic                      stream_valid;
    logic                      stream_ready = 1'b0;
    acc_id_t                   stream_dest;
    logic                      stream_last;
    logic                      acc_done = 1'b0;
    acc_id_t                   acc_done_id = '0;

    // Reference model
    exp_s        exp_q [`CMD_MAX_ACCS][$];
    sub_idx_t    wr_idx [`CMD_MAX_ACCS];
    logic        busy [`CMD_MAX_ACCS];
    queue_addr_t hdr_log [$];

    logic [31:0] rng_stim  = SEED;
    logic [31:0] rng_ready = SEED ^ 32'h9e37_79b9;
    logic [31:0] rng_done  = SEED ^ 32'h7f4a_7c15;
    logic [7:0]  ready_level = 8'd192;
    logic        auto_done = 1'b0;
    logic        done_req = 1'b0;
    acc_id_t     done_req_id = '0;

    logic        hold_pending = 1'b0;
    cmd_word_u   hold_word;
    acc_id_t     hold_dest;
    logic        hold_last;

    int errors   = 0;
    int err_mark = 0;
    int issued   = 0;
    int received = 0;
    int test_num = 0;

    cmd_in_top i_dut (
        .clk          (clk),
        .rstn         (rstn),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .stream_ready (stream_ready),
        .stream_dest  (stream_dest),
        .stream_last  (stream_last),
        .acc_done     (acc_done),
        .acc_done_id  (acc_done_id)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < `CMD_MAX_ACCS; i++) n += exp_q[i].size();
        return n;
    endfunction

    task automatic report(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic check_word(input string name, input cmd_word_u got, input cmd_word_u exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got.raw, exp.raw);
            errors++;
        end
    endtask

    task automatic check_acc(input string name, input acc_id_t got, input acc_id_t exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic write_half(input queue_addr_t a, input logic hi, input logic [31:0] d);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= `APB_ADDR_BITS'({a, hi, 2'b00});
        pwdata  <= d;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);       // No wait state on writes
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_word(input queue_addr_t a, input cmd_word_u w);
        write_half(a, 1'b0, w.raw[31:0]);
        write_half(a, 1'b1, w.raw[63:32]);     // Commits the word
    endtask

    task automatic read_half(input queue_addr_t a, input logic hi, output logic [31:0] d);
        int n;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= `APB_ADDR_BITS'({a, hi, 2'b00});
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pready && n < 8);
        if (!pready) report("APB read never raised PREADY");
        else if (n != 2) report($sformatf("APB read took %0d wait states instead of one", n - 1));
        check_flag("pslverr", pslverr, 1'b0);
        d = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic read_word(input queue_addr_t a, output cmd_word_u w);
        logic [31:0] lo;
        logic [31:0] hi;
        read_half(a, 1'b0, lo);
        read_half(a, 1'b1, hi);
        w.raw = {hi, lo};
    endtask

    // Writes the argument words first and the header last
    task automatic issue_cmd(input acc_id_t a, input cmd_type_e t, input int nargs,
                             output int len);
        cmd_word_u w [$];
        cmd_word_u word;
        exp_s      e;
        sub_idx_t  slot;
        if (t == CMD_SETUP) len = 2;
        else if (t == CMD_EXEC) len = 3 + 2 * nargs;
        else len = 4 + 2 * nargs;
        while (exp_q[a].size() + len + 1 > SUB_DEPTH) @(negedge clk);
        rng_stim = xorshift(rng_stim);
        word.raw          = '0;
        word.hdr.valid    = 1'b1;
        word.hdr.cmd_type = t;
        word.hdr.num_args = nargs[3:0];
        word.hdr.payload  = {rng_stim, rng_stim[15:0] ^ 16'ha5c3};
        w.push_back(word);
        for (int k = 1; k < len; k++) begin
            rng_stim = xorshift(rng_stim);
            word.raw = {1'b0, rng_stim[30:0], ~rng_stim};   // Stale slots never look valid
            w.push_back(word);
        end
        for (int k = 0; k < len; k++) begin
            e.word   = w[k];
            e.last   = k == len - 1;
            e.blocks = e.last && t != CMD_SETUP;
            exp_q[a].push_back(e);
        end
        for (int k = 1; k < len; k++) begin
            slot = wr_idx[a] + sub_idx_t'(k);
            write_word({a, slot}, w[k]);
        end
        write_word({a, wr_idx[a]}, w[0]);
        hdr_log.push_back({a, wr_idx[a]});
        wr_idx[a] = wr_idx[a] + sub_idx_t'(len);
        issued++;
    endtask

    task automatic issue_random(input acc_id_t a, input logic with_setup, input int min_args);
        cmd_type_e t;
        int        len;
        rng_stim = xorshift(rng_stim);
        if (with_setup && rng_stim[1:0] == 2'd0) t = CMD_SETUP;
        else if (rng_stim[2]) t = CMD_PERIODIC;
        else t = CMD_EXEC;
        issue_cmd(a, t, min_args + int'(rng_stim[11:8]) % (16 - min_args), len);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (pending() != 0 && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (pending() != 0) report($sformatf("%0d words never arrived", pending()));
        repeat (4) @(posedge clk);     // Let the header clear land
    endtask

    task automatic request_done(input acc_id_t a);
        done_req_id = a;
        done_req    = 1'b1;
        while (done_req) @(posedge clk);
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (errors == err_mark) $display("test %0d %s: ok", test_num, name);
        else $display("test %0d %s: %0d errors", test_num, name, errors - err_mark);
        err_mark = errors;
    endtask

    always @(posedge clk) begin : ready_driver
        rng_ready = xorshift(rng_ready);
        stream_ready <= rng_ready[7:0] < ready_level;
    end

    // Completion pulses on request or at random for busy accelerators
    always @(posedge clk) begin : done_driver
        acc_id_t a;
        acc_done <= 1'b0;
        rng_done = xorshift(rng_done);
        a = rng_done[`CMD_ACC_BITS-1:0];
        if (rstn && done_req) begin
            acc_done    <= 1'b1;
            acc_done_id <= done_req_id;
            busy[done_req_id] = 1'b0;
            done_req = 1'b0;
        end else if (rstn && auto_done && busy[a] && rng_done[7:5] == 3'd0) begin
            acc_done    <= 1'b1;
            acc_done_id <= a;
            busy[a] = 1'b0;
        end
    end

    // Values at the falling edge are what the next rising edge samples
    always @(negedge clk) begin : stream_monitor
        exp_s    e;
        acc_id_t a;
        if (rstn) begin
            if (hold_pending) begin
                if (!stream_valid) report("stream_valid dropped while stream_ready was low");
                check_word("stream_data", stream_data, hold_word);
                check_acc("stream_dest", stream_dest, hold_dest);
                check_flag("stream_last", stream_last, hold_last);
            end
            hold_pending = stream_valid && !stream_ready;
            hold_word    = stream_data;
            hold_dest    = stream_dest;
            hold_last    = stream_last;
            if (stream_valid && stream_ready) begin
                a = stream_dest;
                if (busy[a]) report($sformatf("accelerator %0d streamed while busy", a));
                if (exp_q[a].size() == 0) begin
                    report($sformatf("unexpected word %h for accelerator %0d", stream_data, a));
                end else begin
                    e = exp_q[a].pop_front();
                    check_word("stream_data", stream_data, e.word);
                    check_flag("stream_last", stream_last, e.last);
                    if (e.blocks) busy[a] = 1'b1;
                    received++;
                end
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_CMDS * 400) @(posedge clk);
        $display("timeout: run did not end within %0d cycles", NUM_CMDS * 400);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main
        cmd_word_u rd;
        int        len;
        rstn    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        for (int i = 0; i < `CMD_MAX_ACCS; i++) begin
            wr_idx[i] = '0;
            busy[i]   = 1'b0;
        end
        // Queue memory starts with invalid headers everywhere
        for (int i = 0; i < `CMD_MAX_ACCS * SUB_DEPTH; i++) begin
            i_dut.i_ram.mem[i] = cmd_word_u'({32'h0, 24'h3c5a00, 8'(i)});
        end
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_flag("stream_valid", stream_valid, 1'b0);

        auto_done = 1'b1;
        repeat (6) issue_random(0, 1'b0, 0);
        wait_drained();
        finish_test("execute and periodic streams");

        // Second command must wait for acc_done
        auto_done = 1'b0;
        issue_cmd(1, CMD_EXEC, 2, len);
        issue_cmd(1, CMD_EXEC, 1, len);
        while (exp_q[1].size() > len) @(negedge clk);
        repeat (200) @(posedge clk);
        if (exp_q[1].size() != len) report("accelerator 1 moved on before its acc_done");
        request_done(1);
        wait_drained();
        finish_test("busy until done");

        issue_cmd(2, CMD_SETUP, 5, len);
        issue_cmd(2, CMD_EXEC, 0, len);
        wait_drained();
        request_done(2);
        finish_test("setup does not block");

        // At least 88 words, so the subqueue wraps
        auto_done = 1'b1;
        hdr_log.delete();
        repeat (8) issue_random(3, 1'b0, 4);
        wait_drained();
        while (hdr_log.size() != 0) begin
            read_word(hdr_log.pop_front(), rd);
            check_flag("header valid", rd.hdr.valid, 1'b0);
        end
        finish_test("header clear and wrap");

        ready_level = 8'd48;
        for (int k = 0; k < 8; k++) issue_random(acc_id_t'(k % 2), 1'b1, 0);
        wait_drained();
        ready_level = 8'd192;
        finish_test("back-pressure");

        for (int k = 0; k < 16; k++) begin
            issue_random(acc_id_t'(k % `CMD_MAX_ACCS), 1'b1, 0);
        end
        wait_drained();
        finish_test("all accelerators");

        $display("summary: %0d tests, %0d commands, %0d words, %0d errors",
                 test_num, issued, received, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+include
logic/cmd_in_pkg.sv
logic/cmd_in_ifs.sv
logic/apb_queue_port.sv
logic/cmd_queue_ram.sv
logic/acc_scheduler.sv
logic/cmd_dispatcher.sv
logic/cmd_in_top.sv
verif/tb_cmd_in.sv

// File: Bender.yml
package:
  name: cmd_in

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cmd_in_pkg.sv
      - logic/cmd_in_ifs.sv
      - logic/apb_queue_port.sv
      - logic/cmd_queue_ram.sv
      - logic/acc_scheduler.sv
      - logic/cmd_dispatcher.sv
      - logic/cmd_in_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_cmd_in.sv
